//--- design/hv_ctrl_pkg.sv
//======================================================================
// hv_ctrl_pkg : shared types and constants for the HV side controller
// state encoding, fault vector, register flags and enable bundle
//======================================================================
`default_nettype none

package hv_ctrl_pkg;

    // controller state
    localparam int CTRL_FSM_ST_W = 4;

    typedef enum logic [CTRL_FSM_ST_W-1:0] {
        PWR_DWN_ST = 4'd0,
        WAIT_ST    = 4'd1,
        TEST_ST    = 4'd2,
        NML_ST     = 4'd3,
        FSISO_ST   = 4'd4,
        FAULT_ST   = 4'd5,
        CFG_ST     = 4'd6,
        RST_ST     = 4'd7,
        BIST_ST    = 4'd8
    } hv_ctrl_st_e;

    // HV fault sources, uv at msb down to scp at lsb
    localparam int HV_ERR_N      = 6;
    localparam int HV_ERR_OC_IDX = 2;   // oc does not block pwm

    // debounce filter
    localparam int FILT_LEN   = 4;
    localparam int FILT_CNT_W = 3;

    typedef struct packed {
        logic uv;
        logic ov;
        logic ot;
        logic oc;
        logic desat;
        logic scp;
    } hv_err_t;

    typedef struct packed {
        logic spi_err;
        logic scan_crc_err;
        logic owt_com_err;
        logic wdg_tmo_err;
        logic bist_fail;
    } reg_stat_t;

    typedef struct packed {
        logic nml_en;
        logic cfg_en;
        logic bist_en;
        logic rst_en;
        logic efuse_vld;    // fuse data valid in regs
        logic efuse_done;   // soft load done, test -> wait
    } reg_mode_t;

    typedef struct packed {
        logic pwm_en;
        logic wdg_scan_en;
        logic spi_en;
        logic owt_com_en;
        logic cfg_reg_en;
        logic test_reg_en;  // also drives analog test mode
        logic efuse_reg_en;
        logic bist_en;
        logic aout_wait;
        logic aout_bist;
    } ctrl_en_t;

endpackage

`default_nettype wire

//--- design/hv_in_sync.sv
//======================================================================
// hv_in_sync : two-stage synchroniser for raw HV faults and fsiso pin
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_in_sync
    import hv_ctrl_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire hv_err_t i_err_raw,     // async from analog front end
    input  wire logic    i_io_fsiso,
    output hv_err_t      o_err_sync,
    output logic         o_io_fsiso
);

    hv_err_t err_meta;      // first stage, may go metastable
    logic    fsiso_meta;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_meta   <= '0;
            fsiso_meta <= 1'b0;
            o_err_sync <= '0;
            o_io_fsiso <= 1'b0;
        end else begin
            err_meta   <= i_err_raw;
            fsiso_meta <= i_io_fsiso;
            o_err_sync <= err_meta;
            o_io_fsiso <= fsiso_meta;
        end
    end

endmodule

`default_nettype wire

//--- design/hv_fault_filter.sv
//======================================================================
// hv_fault_filter : debounce of one fault flag
// output follows the input only after FILT_LEN equal samples in a row
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_fault_filter
    import hv_ctrl_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_err,
    output logic      o_err_filt
);

    logic [FILT_CNT_W-1:0] cnt;
    logic [FILT_CNT_W-1:0] cnt_inc;
    logic                  diff;

    // input disagrees with the filtered level
    assign diff    = i_err ^ o_err_filt;
    assign cnt_inc = cnt + 1'b1;

    //==================================================================
    // run length counter
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt        <= '0;
            o_err_filt <= 1'b0;
        end else if (!diff) begin
            cnt <= '0;                          // glitch ended, start over
        end else if (cnt_inc == FILT_CNT_W'(FILT_LEN)) begin
            cnt        <= '0;
            o_err_filt <= ~o_err_filt;          // new level accepted
        end else begin
            cnt <= cnt_inc;
        end
    end

endmodule

`default_nettype wire

//--- design/hv_ctrl_unit.sv
//======================================================================
// hv_ctrl_unit : HV side controller FSM with registered enable decode,
// interrupt output and eFuse load handshake
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_unit
    import hv_ctrl_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_pwr_on,
    input  wire logic      i_io_test_mode,
    input  wire logic      i_io_fsiso,          // already synchronised
    input  wire logic      i_fsiso_en,
    input  wire hv_err_t   i_hv_err,            // filtered HV faults
    input  wire reg_stat_t i_reg_stat,
    input  wire reg_mode_t i_reg_mode,
    input  wire logic      i_efuse_load_done,
    input  wire logic      i_hv_bist_done,
    output ctrl_en_t       o_ctrl_en,
    output logic           o_intb_n,
    output logic           o_efuse_load_req,
    output hv_ctrl_st_e    o_hv_ctrl_cur_st
);

    hv_ctrl_st_e cur_st;
    hv_ctrl_st_e nxt_st;
    hv_err_t     hv_err_blk;        // faults that stop pwm
    logic        fsiso_act;
    logic        all_err;
    logic        pwm_blk_err;
    logic        cfg_int_err;
    logic        efuse_done_ff;
    ctrl_en_t    ctrl_en_nxt;
    logic        intb_n_nxt;

    //==================================================================
    // error grouping
    //==================================================================
    assign fsiso_act = i_io_fsiso & i_fsiso_en;

    always_comb begin
        hv_err_blk                = i_hv_err;
        hv_err_blk[HV_ERR_OC_IDX] = 1'b0;   // oc keeps pwm alive
    end

    assign all_err = (|i_hv_err) | i_reg_stat.spi_err | i_reg_stat.scan_crc_err
                   | i_reg_stat.owt_com_err | i_reg_stat.wdg_tmo_err;

    assign pwm_blk_err = (|hv_err_blk) | i_reg_stat.owt_com_err
                       | i_reg_stat.wdg_tmo_err;

    assign cfg_int_err = all_err | i_reg_stat.bist_fail;

    //==================================================================
    // eFuse handshake
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            efuse_done_ff <= 1'b0;
        end else begin
            efuse_done_ff <= i_efuse_load_done;
        end
    end

    // level request, held until the fuse macro answers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_efuse_load_req <= 1'b0;
        end else if (i_efuse_load_done) begin
            o_efuse_load_req <= 1'b0;
        end else if (!i_io_test_mode && !i_reg_mode.efuse_vld && (cur_st == WAIT_ST)) begin
            o_efuse_load_req <= 1'b1;
        end
    end

    //==================================================================
    // state machine
    //==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cur_st <= PWR_DWN_ST;
        end else begin
            cur_st <= nxt_st;
        end
    end

    always_comb begin
        nxt_st = cur_st;
        if (!i_pwr_on) begin
            nxt_st = PWR_DWN_ST;                // power loss wins everywhere
        end else if (fsiso_act && (cur_st != PWR_DWN_ST)) begin
            nxt_st = FSISO_ST;
        end else begin
            case (cur_st)
                PWR_DWN_ST: nxt_st = WAIT_ST;
                WAIT_ST: begin
                    if (i_io_test_mode || (efuse_done_ff && !i_reg_mode.efuse_vld)) begin
                        nxt_st = TEST_ST;       // fuse data bad or test pin
                    end else if (!(i_reg_stat.owt_com_err || i_reg_stat.wdg_tmo_err)
                                 && i_reg_mode.nml_en && i_reg_mode.efuse_vld) begin
                        nxt_st = NML_ST;
                    end
                end
                TEST_ST: begin
                    if (i_reg_mode.efuse_done && i_reg_mode.efuse_vld) begin
                        nxt_st = WAIT_ST;
                    end
                end
                NML_ST: begin
                    if (i_reg_mode.cfg_en) begin
                        nxt_st = CFG_ST;
                    end else if (all_err) begin
                        nxt_st = FAULT_ST;
                    end
                end
                FSISO_ST: nxt_st = WAIT_ST;     // pin released
                FAULT_ST: begin
                    if (i_reg_mode.cfg_en) begin
                        nxt_st = CFG_ST;
                    end else if (!all_err) begin
                        nxt_st = NML_ST;
                    end
                end
                CFG_ST: begin
                    if (i_reg_mode.rst_en) begin
                        nxt_st = RST_ST;
                    end else if (!pwm_blk_err && !i_reg_mode.cfg_en) begin
                        nxt_st = FAULT_ST;      // leave via fault, it rechecks errors
                    end else if (!pwm_blk_err && i_reg_mode.bist_en) begin
                        nxt_st = BIST_ST;
                    end else if (!all_err && !i_reg_mode.cfg_en) begin
                        nxt_st = NML_ST;
                    end
                end
                RST_ST: begin
                    if (!i_reg_mode.rst_en) begin
                        nxt_st = WAIT_ST;
                    end
                end
                BIST_ST: begin
                    if (i_reg_mode.cfg_en && !i_reg_mode.bist_en) begin
                        nxt_st = CFG_ST;
                    end
                end
                default: nxt_st = PWR_DWN_ST;
            endcase
        end
    end

    assign o_hv_ctrl_cur_st = cur_st;

    //==================================================================
    // enable and interrupt decode from next state
    //==================================================================
    always_comb begin
        ctrl_en_nxt              = '0;
        ctrl_en_nxt.pwm_en       = (nxt_st == NML_ST) || ((nxt_st == FAULT_ST) && !pwm_blk_err);
        ctrl_en_nxt.wdg_scan_en  = (nxt_st == NML_ST) || (nxt_st == FAULT_ST);
        ctrl_en_nxt.spi_en       = (nxt_st != PWR_DWN_ST);
        ctrl_en_nxt.owt_com_en   = (nxt_st != PWR_DWN_ST) && (nxt_st != WAIT_ST);
        ctrl_en_nxt.cfg_reg_en   = (nxt_st == CFG_ST);
        ctrl_en_nxt.test_reg_en  = (nxt_st == TEST_ST);
        ctrl_en_nxt.efuse_reg_en = (nxt_st == WAIT_ST) || (nxt_st == TEST_ST);
        ctrl_en_nxt.bist_en      = (nxt_st == BIST_ST);
        ctrl_en_nxt.aout_wait    = (nxt_st == WAIT_ST);
        ctrl_en_nxt.aout_bist    = (nxt_st == BIST_ST);
    end

    always_comb begin
        case (nxt_st)
            PWR_DWN_ST, WAIT_ST, FSISO_ST, FAULT_ST, RST_ST: intb_n_nxt = 1'b0;
            CFG_ST:  intb_n_nxt = !cfg_int_err;
            BIST_ST: intb_n_nxt = i_hv_bist_done;   // low while bist runs
            default: intb_n_nxt = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl_en <= '0;
            o_intb_n  <= 1'b0;              // reset behaves as power-down
        end else begin
            o_ctrl_en <= ctrl_en_nxt;
            o_intb_n  <= intb_n_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/hv_ctrl_top.sv
//======================================================================
// hv_ctrl_top : HV side control block
// input sync, per-fault debounce filters and controller FSM
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_top
    import hv_ctrl_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire hv_err_t   i_hv_err_raw,    // async
    input  wire logic      i_io_fsiso,      // async fail-safe pin
    input  wire logic      i_fsiso_en,
    input  wire logic      i_io_test_mode,
    input  wire logic      i_pwr_on,
    input  wire reg_stat_t i_reg_stat,
    input  wire reg_mode_t i_reg_mode,
    input  wire logic      i_efuse_load_done,
    input  wire logic      i_hv_bist_done,
    output ctrl_en_t       o_ctrl_en,
    output logic           o_intb_n,
    output logic           o_efuse_load_req,
    output hv_ctrl_st_e    o_hv_ctrl_cur_st
);

    hv_err_t      err_sync;
    wire hv_err_t err_filt;     // one bit per filter instance
    logic         io_fsiso_sync;

    hv_in_sync u_in_sync (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_err_raw  (i_hv_err_raw),
        .i_io_fsiso (i_io_fsiso),
        .o_err_sync (err_sync),
        .o_io_fsiso (io_fsiso_sync)
    );

    // filter bank
    for (genvar gi = 0; gi < HV_ERR_N; gi++) begin : g_filt
        hv_fault_filter u_filt (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),
            .i_err      (err_sync[gi]),
            .o_err_filt (err_filt[gi])
        );
    end

    hv_ctrl_unit u_ctrl (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_pwr_on          (i_pwr_on),
        .i_io_test_mode    (i_io_test_mode),
        .i_io_fsiso        (io_fsiso_sync),
        .i_fsiso_en        (i_fsiso_en),
        .i_hv_err          (err_filt),
        .i_reg_stat        (i_reg_stat),
        .i_reg_mode        (i_reg_mode),
        .i_efuse_load_done (i_efuse_load_done),
        .i_hv_bist_done    (i_hv_bist_done),
        .o_ctrl_en         (o_ctrl_en),
        .o_intb_n          (o_intb_n),
        .o_efuse_load_req  (o_efuse_load_req),
        .o_hv_ctrl_cur_st  (o_hv_ctrl_cur_st)
    );

endmodule

`default_nettype wire

//--- sim/hv_ctrl_checker.sv
//======================================================================
// hv_ctrl_checker : assertions on controller state, enables and
// eFuse request, bound into the controller FSM
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_checker
    import hv_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_pwr_on,
    input  wire ctrl_en_t    i_ctrl_en,
    input  wire logic        i_efuse_load_req,
    input  wire hv_ctrl_st_e i_cur_st
);

    int fail_cnt = 0;

    pwm_state_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ctrl_en.pwm_en |-> (i_cur_st inside {NML_ST, FAULT_ST}))
        else begin
            $error("pwm enabled outside normal and fault states");
            fail_cnt++;
        end

    // bist and config register access never together
    bist_cfg_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({i_ctrl_en.bist_en, i_ctrl_en.cfg_reg_en}))
        else begin
            $error("bist enable and config register enable both high");
            fail_cnt++;
        end

    efuse_req_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_efuse_load_req) |-> ($past(i_cur_st) == WAIT_ST))
        else begin
            $error("eFuse load request raised outside the wait state");
            fail_cnt++;
        end

    pwr_loss_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_pwr_on |=> (i_cur_st == PWR_DWN_ST))
        else begin
            $error("power loss did not lead to power-down");
            fail_cnt++;
        end

endmodule

bind hv_ctrl_unit hv_ctrl_checker u_checker (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_pwr_on         (i_pwr_on),
    .i_ctrl_en        (o_ctrl_en),
    .i_efuse_load_req (o_efuse_load_req),
    .i_cur_st         (cur_st)
);

`default_nettype wire

//--- sim/hv_ctrl_monitor.sv
//======================================================================
// hv_ctrl_monitor : reference model of the HV controller, per-cycle
// enable and interrupt compare, settled state check per test
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_monitor
    import hv_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_pwr_on,
    input  wire logic        i_io_test_mode,
    input  wire logic        i_fsiso_act,       // synced pin and its enable
    input  wire hv_err_t     i_hv_err_filt,     // faults after debounce
    input  wire reg_stat_t   i_reg_stat,
    input  wire reg_mode_t   i_reg_mode,
    input  wire logic        i_efuse_load_done,
    input  wire logic        i_hv_bist_done,
    input  wire ctrl_en_t    i_ctrl_en,
    input  wire logic        i_intb_n,
    input  wire hv_ctrl_st_e i_cur_st
);

    int          n_tests  = 0;
    int          n_bad    = 0;
    int          n_err    = 0;
    int          err_mark = 0;
    hv_ctrl_st_e model_st;
    logic        done_ff;
    logic        armed;
    hv_err_t     p_err;
    reg_stat_t   p_stat;
    logic        p_bist;
    logic [10:0] exp_v;

    function automatic logic any_err(hv_err_t err, reg_stat_t stat);
        return (|err) | stat.spi_err | stat.scan_crc_err | stat.owt_com_err
             | stat.wdg_tmo_err;
    endfunction

    // oc alone keeps pwm running
    function automatic logic blk_err(hv_err_t err, reg_stat_t stat);
        return err.uv | err.ov | err.ot | err.desat | err.scp | stat.owt_com_err
             | stat.wdg_tmo_err;
    endfunction

    //==================================================================
    // reference one: expected {ctrl_en, intb_n} for a state
    //==================================================================
    function automatic logic [10:0] exp_out(hv_ctrl_st_e st, hv_err_t err,
                                            reg_stat_t stat, logic bist_done);
        ctrl_en_t en;
        logic     intb;
        en              = '0;
        en.pwm_en       = (st == NML_ST) || ((st == FAULT_ST) && !blk_err(err, stat));
        en.wdg_scan_en  = (st == NML_ST) || (st == FAULT_ST);
        en.spi_en       = (st != PWR_DWN_ST);
        en.owt_com_en   = (st != PWR_DWN_ST) && (st != WAIT_ST);
        en.cfg_reg_en   = (st == CFG_ST);
        en.test_reg_en  = (st == TEST_ST);
        en.efuse_reg_en = (st == WAIT_ST) || (st == TEST_ST);
        en.bist_en      = (st == BIST_ST);
        en.aout_wait    = (st == WAIT_ST);
        en.aout_bist    = (st == BIST_ST);
        case (st)
            CFG_ST:          intb = !(any_err(err, stat) | stat.bist_fail);
            BIST_ST:         intb = bist_done;
            NML_ST, TEST_ST: intb = 1'b1;
            default:         intb = 1'b0;
        endcase
        return {en, intb};
    endfunction

    //==================================================================
    // reference two: next state
    //==================================================================
    function automatic hv_ctrl_st_e next_st(hv_ctrl_st_e st, logic pwr, logic tmode,
                                            logic fsiso, hv_err_t err, reg_stat_t stat,
                                            reg_mode_t mode, logic fuse_done);
        logic all_e;
        logic blk_e;
        all_e = any_err(err, stat);
        blk_e = blk_err(err, stat);
        if (!pwr) return PWR_DWN_ST;
        if (fsiso && (st != PWR_DWN_ST)) return FSISO_ST;
        case (st)
            PWR_DWN_ST: return WAIT_ST;
            WAIT_ST: begin
                if (tmode || (fuse_done && !mode.efuse_vld)) return TEST_ST;
                if (!stat.owt_com_err && !stat.wdg_tmo_err && mode.nml_en && mode.efuse_vld)
                    return NML_ST;
            end
            TEST_ST: if (mode.efuse_done && mode.efuse_vld) return WAIT_ST;
            NML_ST: begin
                if (mode.cfg_en) return CFG_ST;
                if (all_e) return FAULT_ST;
            end
            FSISO_ST: return WAIT_ST;
            FAULT_ST: begin
                if (mode.cfg_en) return CFG_ST;
                if (!all_e) return NML_ST;
            end
            CFG_ST: begin
                if (mode.rst_en) return RST_ST;
                if (!blk_e && !mode.cfg_en) return FAULT_ST;
                if (!blk_e && mode.bist_en) return BIST_ST;
                if (!all_e && !mode.cfg_en) return NML_ST;
            end
            RST_ST: if (!mode.rst_en) return WAIT_ST;
            BIST_ST: if (mode.cfg_en && !mode.bist_en) return CFG_ST;
            default: return PWR_DWN_ST;
        endcase
        return st;
    endfunction

    task automatic value_error(input string sig, input logic [15:0] exp,
                               input logic [15:0] got);
        $display("CHECK FAILED %s exp 0x%0h got 0x%0h at %0t ns", sig, exp, got, $time);
        n_err++;
    endtask

    task automatic note_error(input string msg);
        $display("ERROR %s at %0t ns", msg, $time);
        n_err++;
    endtask

    // called once the inputs have been stable for the settle window
    task automatic end_test(input string name, input hv_ctrl_st_e exp_st,
                            input logic exp_pwm, input logic exp_intb);
        if (i_cur_st !== exp_st) value_error("o_hv_ctrl_cur_st", exp_st, i_cur_st);
        if (i_cur_st !== model_st) value_error("o_hv_ctrl_cur_st vs model", model_st, i_cur_st);
        if (i_ctrl_en.pwm_en !== exp_pwm) value_error("o_ctrl_en.pwm_en", exp_pwm, i_ctrl_en.pwm_en);
        if (i_intb_n !== exp_intb) value_error("o_intb_n", exp_intb, i_intb_n);
        n_tests++;
        if (n_err != err_mark) begin
            n_bad++;
            $display("test %s: FAILED with %0d errors", name, n_err - err_mark);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = n_err;
    endtask

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            model_st <= PWR_DWN_ST;
            done_ff  <= 1'b0;
            armed    <= 1'b0;
        end else begin
            model_st <= next_st(model_st, i_pwr_on, i_io_test_mode, i_fsiso_act,
                                i_hv_err_filt, i_reg_stat, i_reg_mode, done_ff);
            done_ff  <= i_efuse_load_done;      // fuse done seen one cycle late
            p_err    <= i_hv_err_filt;
            p_stat   <= i_reg_stat;
            p_bist   <= i_hv_bist_done;
            armed    <= 1'b1;
        end
    end

    // outputs are stable in the low phase
    always @(negedge i_clk) begin
        if (i_rst_n && armed) begin
            exp_v = exp_out(model_st, p_err, p_stat, p_bist);
            if (i_ctrl_en !== exp_v[10:1]) value_error("o_ctrl_en", exp_v[10:1], i_ctrl_en);
            if (i_intb_n !== exp_v[0]) value_error("o_intb_n", exp_v[0], i_intb_n);
        end
    end

endmodule

`default_nettype wire

//--- sim/hv_ctrl_tb.sv
//======================================================================
// hv_ctrl_tb : testbench for the HV side control block
// drives power, faults and mode requests, models the eFuse macro
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_tb
    import hv_ctrl_pkg::*;
();

    localparam int CLK_HALF    = 2;
    localparam int RST_CYC     = 5;
    localparam int SETTLE_CYC  = 8;         // sync, filter and fsm delay
    localparam int EFUSE_LAT   = 3;
    localparam int REQ_WAIT    = 20;
    localparam int TIMEOUT_CYC = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    hv_err_t     hv_err_raw;
    logic        io_fsiso;
    logic        fsiso_en;
    logic        io_test_mode;
    logic        pwr_on;
    reg_stat_t   reg_stat;
    reg_mode_t   reg_mode;
    logic        efuse_load_done = 1'b0;
    logic        hv_bist_done;
    ctrl_en_t    ctrl_en;
    logic        intb_n;
    logic        efuse_load_req;
    hv_ctrl_st_e cur_st;
    int          resp_cnt = 0;
    int          cycles   = 0;
    int          seed     = 32'hd50ad1b9;
    int          glitch_len;
    int          chk_fails;

    always #CLK_HALF clk = ~clk;

    hv_ctrl_top UUT (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_hv_err_raw      (hv_err_raw),
        .i_io_fsiso        (io_fsiso),
        .i_fsiso_en        (fsiso_en),
        .i_io_test_mode    (io_test_mode),
        .i_pwr_on          (pwr_on),
        .i_reg_stat        (reg_stat),
        .i_reg_mode        (reg_mode),
        .i_efuse_load_done (efuse_load_done),
        .i_hv_bist_done    (hv_bist_done),
        .o_ctrl_en         (ctrl_en),
        .o_intb_n          (intb_n),
        .o_efuse_load_req  (efuse_load_req),
        .o_hv_ctrl_cur_st  (cur_st)
    );

    hv_ctrl_monitor u_mon (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_pwr_on          (pwr_on),
        .i_io_test_mode    (io_test_mode),
        .i_fsiso_act       (UUT.io_fsiso_sync & fsiso_en),
        .i_hv_err_filt     (UUT.err_filt),
        .i_reg_stat        (reg_stat),
        .i_reg_mode        (reg_mode),
        .i_efuse_load_done (efuse_load_done),
        .i_hv_bist_done    (hv_bist_done),
        .i_ctrl_en         (ctrl_en),
        .i_intb_n          (intb_n),
        .i_cur_st          (cur_st)
    );

    // eFuse macro, answers a held request after a fixed latency
    always @(negedge clk) begin
        if (!efuse_load_req) begin
            resp_cnt        <= 0;
            efuse_load_done <= 1'b0;
        end else if (resp_cnt == EFUSE_LAT - 1) begin
            efuse_load_done <= 1'b1;
        end else begin
            resp_cnt <= resp_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("tests failed");
            $finish;
        end
    end

    task automatic settle();
        repeat (SETTLE_CYC) @(negedge clk);
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while ((efuse_load_req !== level) && (n < REQ_WAIT)) begin
            @(negedge clk);
            n++;
        end
        if (efuse_load_req !== level) begin
            u_mon.note_error($sformatf("eFuse request did not go to %0b in time", level));
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        hv_err_raw   = '0;
        io_fsiso     = 1'b0;
        fsiso_en     = 1'b0;
        io_test_mode = 1'b0;
        pwr_on       = 1'b0;
        reg_stat     = '0;
        reg_mode     = '0;
        hv_bist_done = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        //==============================================================
        // reset, power-up and eFuse load
        //==============================================================
        settle();
        if (efuse_load_req !== 1'b0) u_mon.note_error("eFuse request active after reset");
        u_mon.end_test("reset", PWR_DWN_ST, 1'b0, 1'b0);
        pwr_on = 1'b1;
        wait_req(1'b1);
        wait_req(1'b0);
        settle();
        u_mon.end_test("power-up to test", TEST_ST, 1'b0, 1'b1);
        reg_mode.efuse_done = 1'b1;
        reg_mode.efuse_vld  = 1'b1;
        settle();
        u_mon.end_test("fuse loaded", WAIT_ST, 1'b0, 1'b0);
        reg_mode.efuse_done = 1'b0;
        reg_mode.nml_en     = 1'b1;
        settle();
        u_mon.end_test("normal", NML_ST, 1'b1, 1'b1);

        //==============================================================
        // fault filtering and overcurrent
        //==============================================================
        glitch_len    = 1 + ($unsigned($random(seed)) % (FILT_LEN - 1));
        hv_err_raw.ot = 1'b1;
        repeat (glitch_len) @(negedge clk);
        hv_err_raw.ot = 1'b0;
        settle();
        u_mon.end_test("ot glitch", NML_ST, 1'b1, 1'b1);
        hv_err_raw.ot = 1'b1;
        settle();
        u_mon.end_test("ot fault", FAULT_ST, 1'b0, 1'b0);
        hv_err_raw.ot = 1'b0;
        settle();
        u_mon.end_test("ot clear", NML_ST, 1'b1, 1'b1);
        hv_err_raw.oc = 1'b1;
        settle();
        u_mon.end_test("oc fault", FAULT_ST, 1'b1, 1'b0);
        hv_err_raw.oc = 1'b0;
        settle();

        //==============================================================
        // config, bist and soft reset
        //==============================================================
        reg_mode.cfg_en = 1'b1;
        settle();
        u_mon.end_test("config", CFG_ST, 1'b0, 1'b1);
        reg_mode.bist_en = 1'b1;
        settle();
        u_mon.end_test("bist running", BIST_ST, 1'b0, 1'b0);
        hv_bist_done = 1'b1;
        settle();
        u_mon.end_test("bist done", BIST_ST, 1'b0, 1'b1);
        reg_mode.bist_en = 1'b0;
        hv_bist_done     = 1'b0;
        settle();
        reg_mode.rst_en = 1'b1;
        settle();
        u_mon.end_test("reset request", RST_ST, 1'b0, 1'b0);
        reg_mode.cfg_en = 1'b0;
        reg_mode.nml_en = 1'b0;
        reg_mode.rst_en = 1'b0;
        settle();
        u_mon.end_test("reset release", WAIT_ST, 1'b0, 1'b0);

        //==============================================================
        // fail-safe pin and power loss
        //==============================================================
        reg_mode.nml_en = 1'b1;
        settle();
        io_fsiso = 1'b1;
        fsiso_en = 1'b1;
        settle();
        u_mon.end_test("fail-safe", FSISO_ST, 1'b0, 1'b0);
        pwr_on = 1'b0;      // pin still active, power loss wins
        settle();
        u_mon.end_test("power loss", PWR_DWN_ST, 1'b0, 1'b0);

        chk_fails = UUT.u_ctrl.u_checker.fail_cnt;
        $display("tests run %0d, tests with errors %0d, check errors %0d, assertion errors %0d",
                 u_mon.n_tests, u_mon.n_bad, u_mon.n_err, chk_fails);
        if ((u_mon.n_err == 0) && (chk_fails == 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/hv_ctrl_pkg.sv
design/hv_in_sync.sv
design/hv_fault_filter.sv
design/hv_ctrl_unit.sv
design/hv_ctrl_top.sv
sim/hv_ctrl_checker.sv
sim/hv_ctrl_monitor.sv
sim/hv_ctrl_tb.sv

//--- Bender.yml
package:
  name: hv_ctrl

sources:
  - files:
      - design/hv_ctrl_pkg.sv
      - design/hv_in_sync.sv
      - design/hv_fault_filter.sv
      - design/hv_ctrl_unit.sv
      - design/hv_ctrl_top.sv
  - target: simulation
    files:
      - sim/hv_ctrl_checker.sv
      - sim/hv_ctrl_monitor.sv
      - sim/hv_ctrl_tb.sv
